/* compile.f */
source/tdc_ctrl_pkg.sv
source/uart_rx.sv
source/main_control.sv
source/tdc_readout.sv
source/uart_tx.sv
source/tdc_ctrl_top.sv
testbench/tdc_ctrl_tb.sv

/* testbench/tdc_ctrl_tb.sv */
`timescale 1ns/1ps

module tdc_ctrl_tb import tdc_ctrl_pkg::*; ();

  localparam int clks_per_bit = 16;
  localparam int boot_cycles  = 40;
  localparam int frame_cycles = 30 * clks_per_bit;  // three bytes on tx

  logic        clk;
  logic        rst;
  logic        rx;
  tdc_result_t f1_result;
  tdc_result_t f2_result;
  logic        tx;
  logic        f1_tdc_enable;
  logic        f2_tdc_enable;
  logic        f1_soft_reset;
  logic        f2_soft_reset;
  logic        pause;

  logic [7:0] rx_q [$];   // bytes decoded from tx
  logic [7:0] exp_q [$];  // bytes still expected, in order
  string      test_name;
  int         error_count;
  int         test_count;
  int         test_errors;
  integer     seed;

  tdc_ctrl_top #(
    .clks_per_bit(clks_per_bit),
    .boot_cycles (boot_cycles)
  ) uut (
    .clk          (clk),
    .rst          (rst),
    .rx           (rx),
    .f1_result    (f1_result),
    .f2_result    (f2_result),
    .tx           (tx),
    .f1_tdc_enable(f1_tdc_enable),
    .f2_tdc_enable(f2_tdc_enable),
    .f1_soft_reset(f1_soft_reset),
    .f2_soft_reset(f2_soft_reset),
    .pause        (pause)
  );

  always #50 clk = ~clk;

  // expected frame: tag byte, high byte, low byte
  function automatic logic [23:0] frame_of(input int ch, input logic [15:0] value);
    logic [7:0] tag;
    tag = (ch == 1) ? tag_ch1 : tag_ch2;
    return {tag, value[15:8], value[7:0]};
  endfunction

  task automatic compare_values(input string name, input logic [31:0] expected,
                                input logic [31:0] actual);
    if (actual !== expected) begin
      $display("MISMATCH %s expected %0h actual %0h", name, expected, actual);
      error_count++;
    end
  endtask

  task automatic expect_frame(input int ch, input logic [15:0] value);
    logic [23:0] f;
    f = frame_of(ch, value);
    exp_q.push_back(f[23:16]);
    exp_q.push_back(f[15:8]);
    exp_q.push_back(f[7:0]);
  endtask

  task automatic send_byte(input logic [7:0] b);
    logic [9:0] bits;
    bits = {1'b1, b, 1'b0};  // stop, data, start
    for (int i = 0; i < 10; i++) begin
      rx = bits[i];
      repeat (clks_per_bit) @(negedge clk);
    end
  endtask

  task automatic strobe_result(input int ch, input logic [15:0] value);
    if (ch == 1) begin
      f1_result = '{value: value, valid: 1'b1};
    end else begin
      f2_result = '{value: value, valid: 1'b1};
    end
    @(negedge clk);
    f1_result.valid = 1'b0;
    f2_result.valid = 1'b0;
  endtask

  task automatic wait_frames_sent(input int timeout);
    int cycles;
    cycles = 0;
    while (exp_q.size() != 0 && cycles < timeout) begin
      @(negedge clk);
      cycles++;
    end
    if (exp_q.size() != 0) begin
      $display("timeout in %s: %0d expected bytes never came out on tx", test_name,
               exp_q.size());
      error_count++;
      exp_q.delete();
    end
  endtask

  task automatic quiet_window(input int cycles);
    int low_cycles;
    low_cycles = 0;
    repeat (cycles) begin
      @(negedge clk);
      if (tx !== 1'b1) low_cycles++;
    end
    compare_values({test_name, " tx idle"}, 0, low_cycles);
  endtask

  // enable low then high, boot_cycles high, then one soft-reset pulse
  task automatic check_power_up(input bit was_enabled);
    int cycles;
    int low_cycles;
    int drops;
    cycles = 0;
    while (was_enabled && f1_tdc_enable !== 1'b0 && cycles < 400) begin
      @(negedge clk);
      cycles++;
    end
    if (was_enabled && f1_tdc_enable !== 1'b0) begin
      $display("timeout in %s: TDC enable never went low", test_name);
      error_count++;
    end
    low_cycles = 0;
    while (f1_tdc_enable === 1'b0 && low_cycles < 400) begin
      low_cycles++;
      @(negedge clk);
    end
    if (f1_tdc_enable !== 1'b1) begin
      $display("timeout in %s: TDC enable never went high", test_name);
      error_count++;
    end
    if (was_enabled) compare_values({test_name, " enable low cycles"}, 1, low_cycles);
    compare_values({test_name, " f2 enable"}, 1, f2_tdc_enable);
    cycles = 0;
    drops = 0;
    while (f1_soft_reset !== 1'b1 && cycles < boot_cycles + 20) begin
      f1_result = '{value: 16'hbeef, valid: (cycles == boot_cycles / 2)};  // ignored in boot
      @(negedge clk);
      cycles++;
      if (f1_tdc_enable !== 1'b1 || f2_tdc_enable !== 1'b1) drops++;
    end
    f1_result.valid = 1'b0;
    if (f1_soft_reset !== 1'b1) begin
      $display("timeout in %s: soft reset never pulsed", test_name);
      error_count++;
    end
    compare_values({test_name, " boot cycles"}, boot_cycles, cycles);
    compare_values({test_name, " enable drops"}, 0, drops);
    compare_values({test_name, " f2 soft reset"}, 1, f2_soft_reset);
    @(negedge clk);
    compare_values({test_name, " soft reset width"}, 0, {f1_soft_reset, f2_soft_reset});
  endtask

  task automatic begin_test(input string name);
    test_name   = name;
    test_errors = error_count;
  endtask

  task automatic end_test();
    test_count++;
    if (error_count == test_errors) begin
      $display("%s: pass", test_name);
    end else begin
      $display("%s: %0d errors", test_name, error_count - test_errors);
    end
  endtask

  always begin : tx_monitor
    logic [7:0] b;
    @(negedge clk);
    if (tx === 1'b0) begin
      repeat (clks_per_bit / 2) @(negedge clk);  // middle of start bit
      for (int i = 0; i < 8; i++) begin
        repeat (clks_per_bit) @(negedge clk);
        b[i] = tx;
      end
      repeat (clks_per_bit) @(negedge clk);
      if (tx !== 1'b1) begin
        $display("stop bit on tx was low during %s", test_name);
        error_count++;
      end
      rx_q.push_back(b);
    end
  end

  always begin : byte_compare
    logic [7:0] got;
    @(negedge clk);
    while (rx_q.size() > 0) begin
      got = rx_q.pop_front();
      if (exp_q.size() == 0) begin
        $display("unexpected byte %h came out on tx during %s", got, test_name);
        error_count++;
      end else begin
        compare_values(test_name, exp_q.pop_front(), got);
      end
    end
  end

  initial begin
    logic [15:0] v1;
    logic [15:0] v2;
    int          ch;
    int          bad;
    clk         = 1'b0;
    rst         = 1'b1;
    rx          = 1'b1;
    f1_result   = '0;
    f2_result   = '0;
    error_count = 0;
    test_count  = 0;
    seed        = 32'h4b11;
    begin_test("reset");
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    begin_test("after_reset");
    compare_values({test_name, " enables"}, 0, {f1_tdc_enable, f2_tdc_enable});
    compare_values({test_name, " soft resets"}, 0, {f1_soft_reset, f2_soft_reset});
    compare_values({test_name, " pause"}, 0, pause);
    compare_values({test_name, " tx"}, 1, tx);
    strobe_result(1, 16'h1234);  // not enabled yet
    quiet_window(frame_cycles + 100);
    end_test();

    begin_test("power_up");
    fork
      send_byte(cmd_start);
      check_power_up(1'b0);
    join
    quiet_window(frame_cycles + 100);
    end_test();

    begin_test("single_results");
    for (int i = 0; i < 6; i++) begin
      v1 = 16'($random(seed));
      ch = (i % 2) + 1;
      expect_frame(ch, v1);
      strobe_result(ch, v1);
      wait_frames_sent(2 * frame_cycles);
      repeat (20) @(negedge clk);
    end
    end_test();

    begin_test("both_channels");
    v1 = 16'($random(seed));
    v2 = 16'($random(seed));
    expect_frame(1, v1);  // channel 1 goes first
    expect_frame(2, v2);
    f1_result = '{value: v1, valid: 1'b1};
    strobe_result(2, v2);
    wait_frames_sent(3 * frame_cycles);
    end_test();

    begin_test("pause_play");
    send_byte(cmd_pause);
    compare_values({test_name, " pause after s"}, 1, pause);
    strobe_result(1, 16'($random(seed)));
    quiet_window(frame_cycles + 100);
    send_byte(cmd_play);
    compare_values({test_name, " pause after p"}, 0, pause);
    v2 = 16'($random(seed));
    expect_frame(2, v2);
    strobe_result(2, v2);
    wait_frames_sent(2 * frame_cycles);
    end_test();

    begin_test("other_bytes_restart");
    bad = 0;
    fork
      begin
        send_byte(8'h55);
        send_byte(8'h44);  // upper case 'D'
      end
      repeat (20 * clks_per_bit + 20) begin
        @(negedge clk);
        if (f1_tdc_enable !== 1'b1 || f2_tdc_enable !== 1'b1 || pause !== 1'b0 ||
            f1_soft_reset !== 1'b0 || f2_soft_reset !== 1'b0) bad++;
      end
    join
    compare_values({test_name, " disturbed cycles"}, 0, bad);
    fork
      send_byte(cmd_start);
      check_power_up(1'b1);
    join
    v1 = 16'($random(seed));
    expect_frame(1, v1);
    strobe_result(1, v1);
    wait_frames_sent(2 * frame_cycles);
    quiet_window(frame_cycles + 100);  // no repeated frame
    end_test();

    $display("tests run %0d, errors %0d", test_count, error_count);
    if (error_count == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

/* source/tdc_ctrl_top.sv */
`timescale 1ns/1ps

module tdc_ctrl_top import tdc_ctrl_pkg::*; #(
  parameter int clks_per_bit = 16,
  parameter int boot_cycles  = 40
) (
  input  logic        clk,
  input  logic        rst,
  input  logic        rx,
  input  tdc_result_t f1_result,
  input  tdc_result_t f2_result,
  output logic        tx,
  output logic        f1_tdc_enable,
  output logic        f2_tdc_enable,
  output logic        f1_soft_reset,
  output logic        f2_soft_reset,
  output logic        pause
);

  logic [7:0]   rx_data;
  logic         new_rx_data;  // one-cycle byte strobe
  ctrl_status_t status;
  logic [7:0]   tx_data;
  logic         tx_start;
  logic         tx_busy;

  uart_rx #(
    .clks_per_bit(clks_per_bit)
  ) u_uart_rx (
    .clk        (clk),
    .rst        (rst),
    .rx         (rx),
    .rx_data    (rx_data),
    .new_rx_data(new_rx_data)
  );

  main_control #(
    .boot_cycles(boot_cycles)
  ) u_main_control (
    .clk          (clk),
    .rst          (rst),
    .rx_data      (rx_data),
    .new_rx_data  (new_rx_data),
    .f1_tdc_enable(f1_tdc_enable),
    .f2_tdc_enable(f2_tdc_enable),
    .f1_soft_reset(f1_soft_reset),
    .f2_soft_reset(f2_soft_reset),
    .pause        (pause),
    .status       (status)
  );

  tdc_readout u_tdc_readout (
    .clk      (clk),
    .rst      (rst),
    .status   (status),
    .f1_result(f1_result),
    .f2_result(f2_result),
    .tx_busy  (tx_busy),
    .tx_data  (tx_data),
    .tx_start (tx_start)
  );

  uart_tx #(
    .clks_per_bit(clks_per_bit)
  ) u_uart_tx (
    .clk     (clk),
    .rst     (rst),
    .tx_data (tx_data),
    .tx_start(tx_start),
    .tx      (tx),
    .tx_busy (tx_busy)
  );

endmodule

/* source/uart_tx.sv */
`timescale 1ns/1ps

module uart_tx #(
  parameter int clks_per_bit = 16
) (
  input  logic       clk,
  input  logic       rst,
  input  logic [7:0] tx_data,
  input  logic       tx_start,
  output logic       tx,
  output logic       tx_busy
);

  localparam int cnt_w = $clog2(clks_per_bit);

  logic [cnt_w-1:0] clk_cnt_q;
  logic [3:0]       bit_cnt_q;  // 0 is the start bit, 9 the stop bit
  logic [8:0]       shift_q;    // data bits, then stop bit
  logic             bit_tick;

  assign bit_tick = (clk_cnt_q == cnt_w'(clks_per_bit - 1));

  always_ff @(posedge clk) begin
    if (rst) begin
      tx        <= 1'b1;  // idle high
      tx_busy   <= 1'b0;
      clk_cnt_q <= '0;
      bit_cnt_q <= '0;
    end else if (!tx_busy) begin
      clk_cnt_q <= '0;
      bit_cnt_q <= '0;
      if (tx_start) begin
        tx      <= 1'b0;  // start bit
        tx_busy <= 1'b1;
      end
    end else if (bit_tick) begin
      clk_cnt_q <= '0;
      if (bit_cnt_q == 4'd9) begin
        tx_busy <= 1'b0;  // stop bit finished
      end else begin
        tx        <= shift_q[0];
        bit_cnt_q <= bit_cnt_q + 1'b1;
      end
    end else begin
      clk_cnt_q <= clk_cnt_q + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (!tx_busy && tx_start) begin
      shift_q <= {1'b1, tx_data};
    end else if (tx_busy && bit_tick) begin
      shift_q <= {1'b1, shift_q[8:1]};  // lsb first
    end
  end

endmodule

/* source/tdc_readout.sv */
`timescale 1ns/1ps

module tdc_readout import tdc_ctrl_pkg::*; (
  input  logic         clk,
  input  logic         rst,
  input  ctrl_status_t status,
  input  tdc_result_t  f1_result,
  input  tdc_result_t  f2_result,
  input  logic         tx_busy,
  output logic [7:0]   tx_data,
  output logic         tx_start
);

  tdc_result_t result [2];
  logic [15:0] hold_q [2];   // one-entry holding register per channel
  logic [1:0]  pend_q;
  logic [1:0]  renew_q;      // captured again since its frame was latched
  logic [1:0]  take;
  logic [15:0] frame_q;      // word being framed
  logic [1:0]  byte_cnt_q;   // 0 idle, 1 tag out, 2 high byte out
  logic        cur_ch_q;
  logic        next_ch;
  logic        slot;         // transmitter can take a byte
  logic        launch;

  assign result[0] = f1_result;
  assign result[1] = f2_result;
  assign next_ch   = !pend_q[0];  // channel 1 wins
  assign slot      = !tx_busy && !tx_start;
  assign launch    = slot && (byte_cnt_q == 2'd0) && (pend_q != 2'b00);

  always_comb begin
    for (int ch = 0; ch < 2; ch++) begin
      take[ch] = result[ch].valid && status.enabled && !status.paused;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pend_q     <= 2'b00;
      renew_q    <= 2'b00;
      byte_cnt_q <= 2'd0;
      cur_ch_q   <= 1'b0;
      tx_start   <= 1'b0;
    end else begin
      tx_start <= 1'b0;
      if (launch) begin
        cur_ch_q         <= next_ch;
        renew_q[next_ch] <= 1'b0;
        byte_cnt_q       <= 2'd1;
        tx_start         <= 1'b1;
      end else if (slot && byte_cnt_q != 2'd0) begin
        tx_start   <= 1'b1;
        byte_cnt_q <= (byte_cnt_q == 2'd2) ? 2'd0 : 2'd2;
        if (byte_cnt_q == 2'd2 && !renew_q[cur_ch_q]) begin
          pend_q[cur_ch_q] <= 1'b0;  // last byte, nothing newer waiting
        end
      end
      for (int ch = 0; ch < 2; ch++) begin
        if (take[ch]) begin
          pend_q[ch]  <= 1'b1;
          renew_q[ch] <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    for (int ch = 0; ch < 2; ch++) begin
      if (take[ch]) begin
        hold_q[ch] <= result[ch].value;  // newer result overwrites
      end
    end
    if (launch) begin
      frame_q <= hold_q[next_ch];
      tx_data <= next_ch ? tag_ch2 : tag_ch1;
    end else if (slot && byte_cnt_q == 2'd1) begin
      tx_data <= frame_q[15:8];
    end else if (slot && byte_cnt_q == 2'd2) begin
      tx_data <= frame_q[7:0];
    end
  end

  assert property (@(posedge clk) disable iff (rst) tx_start |-> !tx_busy)
    else $error("tdc_readout: tx_start while transmitter busy");

endmodule

/* source/main_control.sv */
`timescale 1ns/1ps

module main_control import tdc_ctrl_pkg::*; #(
  parameter int boot_cycles = 40
) (
  input  logic         clk,
  input  logic         rst,
  input  logic [7:0]   rx_data,
  input  logic         new_rx_data,
  output logic         f1_tdc_enable,
  output logic         f2_tdc_enable,
  output logic         f1_soft_reset,
  output logic         f2_soft_reset,
  output logic         pause,
  output ctrl_status_t status
);

  localparam int cnt_w = $clog2(boot_cycles + 1);

  typedef enum logic [1:0] {idle, enable_low, enable_high, soft_reset} state_t;

  state_t           state_q;
  state_t           state_d;
  logic [cnt_w-1:0] boot_cnt_q;
  logic             enable_q;
  logic             soft_reset_q;
  logic             pause_q;
  logic             booted_q;    // power-up sequence completed
  logic             is_start;
  logic             is_pause;
  logic             is_play;

  assign is_start = new_rx_data && (rx_data == cmd_start);
  assign is_pause = new_rx_data && (rx_data == cmd_pause);
  assign is_play  = new_rx_data && (rx_data == cmd_play);

  assign f1_tdc_enable  = enable_q;  // shared enable
  assign f2_tdc_enable  = enable_q;
  assign f1_soft_reset  = soft_reset_q;
  assign f2_soft_reset  = soft_reset_q;
  assign pause          = pause_q;
  assign status.enabled = enable_q && booted_q;
  assign status.paused  = pause_q;

  always_comb begin
    state_d = state_q;
    case (state_q)
      idle: begin
        if (is_start) begin
          state_d = enable_low;
        end
      end
      enable_low:  state_d = enable_high;
      enable_high: begin
        if (boot_cnt_q == cnt_w'(boot_cycles - 1)) begin
          state_d = soft_reset;  // TDC has had its boot time
        end
      end
      default:     state_d = idle;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q      <= idle;
      boot_cnt_q   <= '0;
      enable_q     <= 1'b0;
      soft_reset_q <= 1'b0;
      pause_q      <= 1'b0;
      booted_q     <= 1'b0;
    end else begin
      state_q      <= state_d;
      soft_reset_q <= (state_d == soft_reset);  // registered pulse, no glitches
      boot_cnt_q   <= (state_q == enable_high) ? boot_cnt_q + 1'b1 : '0;
      if (state_d == enable_low) begin
        enable_q <= 1'b0;
        booted_q <= 1'b0;
      end else if (state_d == enable_high) begin
        enable_q <= 1'b1;
      end
      if (state_q == soft_reset) begin
        booted_q <= 1'b1;
      end
      if (state_q == idle) begin
        if (is_pause) begin
          pause_q <= 1'b1;
        end else if (is_play) begin
          pause_q <= 1'b0;
        end
      end
    end
  end

  assert property (@(posedge clk) disable iff (rst) f1_soft_reset |=> !f1_soft_reset)
    else $error("main_control: soft reset longer than one cycle");

  assert property (@(posedge clk) disable iff (rst) $rose(f1_soft_reset) |-> f1_tdc_enable)
    else $error("main_control: soft reset raised while enable low");

endmodule

/* source/uart_rx.sv */
`timescale 1ns/1ps

module uart_rx #(
  parameter int clks_per_bit = 16
) (
  input  logic       clk,
  input  logic       rst,
  input  logic       rx,
  output logic [7:0] rx_data,
  output logic       new_rx_data
);

  localparam int cnt_w = $clog2(clks_per_bit);

  typedef enum logic [1:0] {idle, start, data, stop} state_t;

  state_t           state_q;
  logic [1:0]       sync_q;     // two-flop synchronizer
  logic [cnt_w-1:0] clk_cnt_q;
  logic [2:0]       bit_cnt_q;
  logic [7:0]       shift_q;
  logic             rx_s;
  logic             bit_tick;   // middle of the current bit

  assign rx_s     = sync_q[1];
  assign bit_tick = (clk_cnt_q == cnt_w'(clks_per_bit - 1));

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q     <= idle;
      sync_q      <= 2'b11;  // line idles high
      clk_cnt_q   <= '0;
      bit_cnt_q   <= '0;
      new_rx_data <= 1'b0;
    end else begin
      sync_q      <= {sync_q[0], rx};
      new_rx_data <= 1'b0;
      case (state_q)
        idle: begin
          clk_cnt_q <= '0;
          if (!rx_s) begin
            state_q <= start;
          end
        end
        start: begin
          if (clk_cnt_q == cnt_w'(clks_per_bit / 2 - 1)) begin
            clk_cnt_q <= '0;
            bit_cnt_q <= '0;
            state_q   <= rx_s ? idle : data;  // high again means a glitch
          end else begin
            clk_cnt_q <= clk_cnt_q + 1'b1;
          end
        end
        data: begin
          if (bit_tick) begin
            clk_cnt_q <= '0;
            bit_cnt_q <= bit_cnt_q + 1'b1;
            if (bit_cnt_q == 3'd7) begin
              state_q <= stop;
            end
          end else begin
            clk_cnt_q <= clk_cnt_q + 1'b1;
          end
        end
        default: begin
          if (bit_tick) begin
            clk_cnt_q   <= '0;
            state_q     <= idle;
            new_rx_data <= rx_s;  // low stop bit is a framing error
          end else begin
            clk_cnt_q <= clk_cnt_q + 1'b1;
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state_q == data && bit_tick) begin
      shift_q <= {rx_s, shift_q[7:1]};  // lsb arrives first
    end
    if (state_q == stop && bit_tick && rx_s) begin
      rx_data <= shift_q;
    end
  end

  assert property (@(posedge clk) disable iff (rst) new_rx_data |=> !new_rx_data)
    else $error("uart_rx: new_rx_data high for two cycles");

endmodule

/* source/tdc_ctrl_pkg.sv */
package tdc_ctrl_pkg;

  // command bytes received on the serial line
  localparam logic [7:0] cmd_start = 8'h64;  // 'd'
  localparam logic [7:0] cmd_pause = 8'h73;  // 's'
  localparam logic [7:0] cmd_play  = 8'h70;  // 'p'

  // channel tags leading each result frame
  localparam logic [7:0] tag_ch1 = 8'h41;  // 'A'
  localparam logic [7:0] tag_ch2 = 8'h42;  // 'B'

  // one measurement word from a TDC channel
  typedef struct packed {
    logic [15:0] value;
    logic        valid;  // one-cycle strobe
  } tdc_result_t;

  // controller state seen by the readout
  typedef struct packed {
    logic enabled;  // enable high and boot finished
    logic paused;
  } ctrl_status_t;

endpackage
